// File: rtl/fm_radio_macros.svh
`ifndef FM_RADIO_MACROS_SVH
`define FM_RADIO_MACROS_SVH

// sample word and input stream widths
`define FM_DATA_SIZE  32
`define FM_BYTE_SIZE  8

// raw I or Q field inside a frame
`define FM_CHAR_SIZE  16

// fixed-point position, scaled up on input and back down at the gain
`define FM_QUANT_BITS 10

// same depth for every fifo in the chain
`define FM_FIFO_DEPTH 128

`endif

// File: rtl/fm_radio_pkg.sv
`include "fm_radio_macros.svh"

package fm_radio_pkg;

    // signed sample on every path after the frame reader
    typedef logic signed [`FM_DATA_SIZE-1:0] sample_t;

    // one input frame: raw bytes in arrival order, or the two fields
    // byte 0 lands in bits 7:0, so both fields come out little-endian
    typedef union packed {
        logic [`FM_DATA_SIZE/`FM_BYTE_SIZE-1:0][`FM_BYTE_SIZE-1:0] bytes;
        struct packed {
            logic [`FM_CHAR_SIZE-1:0] q;
            logic [`FM_CHAR_SIZE-1:0] i;
        } fields;
    } iq_frame_t;

endpackage

// File: rtl/fifo.sv
`timescale 1ns/100ps
`include "fm_radio_macros.svh"

module fifo #(
    parameter int FIFO_DATA_WIDTH  = `FM_DATA_SIZE,
    parameter int FIFO_BUFFER_SIZE = `FM_FIFO_DEPTH
) (
    input  logic                       clock,
    input  logic                       i_rst,
    input  logic                       i_wr_en,
    input  logic [FIFO_DATA_WIDTH-1:0] i_din,
    output logic                       o_full,
    input  logic                       i_rd_en,
    output logic [FIFO_DATA_WIDTH-1:0] o_dout,
    output logic                       o_empty
);

    localparam int PTR_WIDTH = $clog2(FIFO_BUFFER_SIZE);
    localparam int CNT_WIDTH = $clog2(FIFO_BUFFER_SIZE + 1);

    logic [FIFO_DATA_WIDTH-1:0] mem [FIFO_BUFFER_SIZE];
    logic [PTR_WIDTH-1:0]       wr_ptr;
    logic [PTR_WIDTH-1:0]       rd_ptr;
    logic [CNT_WIDTH-1:0]       count;
    logic                       do_wr;
    logic                       do_rd;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(FIFO_BUFFER_SIZE - 1)) begin
            return '0;
        end
        return ptr + PTR_WIDTH'(1);
    endfunction

    assign do_wr = i_wr_en && !o_full;
    assign do_rd = i_rd_en && !o_empty;

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clock) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_WIDTH'(do_wr) - CNT_WIDTH'(do_rd);
        end
    end

    // first word falls through, head is visible while not empty
    assign o_dout  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_WIDTH'(FIFO_BUFFER_SIZE));

endmodule

// File: rtl/read_iq.sv
`timescale 1ns/100ps
`include "fm_radio_macros.svh"

module read_iq (
    input  logic                      clock,
    input  logic                      i_rst,
    input  logic [`FM_BYTE_SIZE-1:0]  i_in_dout,
    input  logic                      i_in_empty,
    output logic                      o_in_rd_en,
    input  logic                      i_i_full,
    input  logic                      i_q_full,
    output logic                      o_out_wr_en,
    output fm_radio_pkg::sample_t     o_i_out,
    output fm_radio_pkg::sample_t     o_q_out
);

    import fm_radio_pkg::*;

    iq_frame_t  frame;
    logic [1:0] byte_cnt;
    logic       frame_valid;

    // no popping while a finished frame waits for room downstream
    assign o_in_rd_en  = !i_in_empty && !frame_valid;
    assign o_out_wr_en = frame_valid && !i_i_full && !i_q_full;

    always_ff @(posedge clock) begin
        if (o_in_rd_en) begin
            frame.bytes[byte_cnt] <= i_in_dout;
        end
    end

    always_ff @(posedge clock) begin
        if (i_rst) begin
            byte_cnt    <= 2'd0;
            frame_valid <= 1'b0;
        end else begin
            if (o_in_rd_en) begin
                byte_cnt <= byte_cnt + 2'd1;
                // fourth byte completes the frame
                if (byte_cnt == 2'd3) begin
                    frame_valid <= 1'b1;
                end
            end
            if (o_out_wr_en) begin
                frame_valid <= 1'b0;
            end
        end
    end

    // sign extend each 16-bit field, then move it to fixed point
    assign o_i_out = sample_t'($signed(frame.fields.i)) <<< `FM_QUANT_BITS;
    assign o_q_out = sample_t'($signed(frame.fields.q)) <<< `FM_QUANT_BITS;

endmodule

// File: rtl/stereo_matrix.sv
`timescale 1ns/100ps

module stereo_matrix (
    input  logic                  clock,
    input  logic                  i_rst,
    input  fm_radio_pkg::sample_t i_lpr_dout,
    input  logic                  i_lpr_empty,
    output logic                  o_lpr_rd_en,
    input  fm_radio_pkg::sample_t i_lmr_dout,
    input  logic                  i_lmr_empty,
    output logic                  o_lmr_rd_en,
    output logic                  o_left_wr_en,
    output fm_radio_pkg::sample_t o_left_din,
    input  logic                  i_left_full,
    output logic                  o_right_wr_en,
    output fm_radio_pkg::sample_t o_right_din,
    input  logic                  i_right_full
);

    import fm_radio_pkg::*;

    sample_t sum;
    sample_t diff;
    logic    go;
    logic    wr_pending;

    // (l+r) + (l-r) = 2l, (l+r) - (l-r) = 2r
    assign sum  = i_lpr_dout + i_lmr_dout;
    assign diff = i_lpr_dout - i_lmr_dout;

    // one registered write in flight at a time, so a sampled
    // full flag cannot be stale when the write lands
    assign go = !i_lpr_empty && !i_lmr_empty && !i_left_full && !i_right_full
                && !wr_pending;

    assign o_lpr_rd_en   = go;
    assign o_lmr_rd_en   = go;
    assign o_left_wr_en  = wr_pending;
    assign o_right_wr_en = wr_pending;

    always_ff @(posedge clock) begin
        if (go) begin
            o_left_din  <= sum;
            o_right_din <= diff;
        end
    end

    always_ff @(posedge clock) begin
        if (i_rst) begin
            wr_pending <= 1'b0;
        end else begin
            wr_pending <= go;
        end
    end

endmodule

// File: rtl/gain.sv
`timescale 1ns/100ps
`include "fm_radio_macros.svh"

module gain (
    input  logic                  clock,
    input  logic                  i_rst,
    input  fm_radio_pkg::sample_t i_volume,
    input  fm_radio_pkg::sample_t i_in_dout,
    input  logic                  i_in_empty,
    output logic                  o_in_rd_en,
    output fm_radio_pkg::sample_t o_out_din,
    output logic                  o_out_wr_en,
    input  logic                  i_out_full
);

    import fm_radio_pkg::*;

    sample_t product;
    logic    result_valid;

    // low word of the product only
    assign product = i_in_dout * i_volume;

    assign o_out_wr_en = result_valid && !i_out_full;
    // refill the result register as it empties
    assign o_in_rd_en  = !i_in_empty && (!result_valid || o_out_wr_en);

    always_ff @(posedge clock) begin
        if (o_in_rd_en) begin
            o_out_din <= product >>> `FM_QUANT_BITS;
        end
    end

    always_ff @(posedge clock) begin
        if (i_rst) begin
            result_valid <= 1'b0;
        end else if (o_in_rd_en) begin
            result_valid <= 1'b1;
        end else if (o_out_wr_en) begin
            result_valid <= 1'b0;
        end
    end

endmodule

// File: rtl/fm_radio_top.sv
`timescale 1ns/100ps
`include "fm_radio_macros.svh"

module fm_radio_top (
    input  logic                     clock,
    input  logic                     i_rst,
    input  logic                     i_in_wr_en,
    input  logic [`FM_BYTE_SIZE-1:0] i_in_din,
    output logic                     o_in_full,
    input  fm_radio_pkg::sample_t    i_volume,
    input  logic                     i_left_rd_en,
    output logic                     o_left_empty,
    output fm_radio_pkg::sample_t    o_left_data,
    input  logic                     i_right_rd_en,
    output logic                     o_right_empty,
    output fm_radio_pkg::sample_t    o_right_data
);

    import fm_radio_pkg::*;

    logic [`FM_BYTE_SIZE-1:0] in_dout;
    logic                     in_empty;
    logic                     in_rd_en;

    // i stands for l+r, q for l-r
    logic    iq_wr_en;
    sample_t lpr_din;
    sample_t lmr_din;
    logic    lpr_full;
    logic    lmr_full;
    sample_t lpr_dout;
    sample_t lmr_dout;
    logic    lpr_empty;
    logic    lmr_empty;
    logic    lpr_rd_en;
    logic    lmr_rd_en;

    logic    left_sum_wr_en;
    sample_t left_sum_din;
    logic    left_sum_full;
    sample_t left_sum_dout;
    logic    left_sum_empty;
    logic    left_sum_rd_en;

    logic    right_diff_wr_en;
    sample_t right_diff_din;
    logic    right_diff_full;
    sample_t right_diff_dout;
    logic    right_diff_empty;
    logic    right_diff_rd_en;

    logic    left_gain_wr_en;
    sample_t left_gain_din;
    logic    left_gain_full;
    logic    right_gain_wr_en;
    sample_t right_gain_din;
    logic    right_gain_full;

    fifo #(.FIFO_DATA_WIDTH(`FM_BYTE_SIZE), .FIFO_BUFFER_SIZE(`FM_FIFO_DEPTH)) fifo_in_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_wr_en(i_in_wr_en),
        .i_din(i_in_din),
        .o_full(o_in_full),
        .i_rd_en(in_rd_en),
        .o_dout(in_dout),
        .o_empty(in_empty)
    );

    read_iq read_iq_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_in_dout(in_dout),
        .i_in_empty(in_empty),
        .o_in_rd_en(in_rd_en),
        .i_i_full(lpr_full),
        .i_q_full(lmr_full),
        .o_out_wr_en(iq_wr_en),
        .o_i_out(lpr_din),
        .o_q_out(lmr_din)
    );

    fifo #(.FIFO_DATA_WIDTH(`FM_DATA_SIZE), .FIFO_BUFFER_SIZE(`FM_FIFO_DEPTH)) fifo_i_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_wr_en(iq_wr_en),
        .i_din(lpr_din),
        .o_full(lpr_full),
        .i_rd_en(lpr_rd_en),
        .o_dout(lpr_dout),
        .o_empty(lpr_empty)
    );

    fifo #(.FIFO_DATA_WIDTH(`FM_DATA_SIZE), .FIFO_BUFFER_SIZE(`FM_FIFO_DEPTH)) fifo_q_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_wr_en(iq_wr_en),
        .i_din(lmr_din),
        .o_full(lmr_full),
        .i_rd_en(lmr_rd_en),
        .o_dout(lmr_dout),
        .o_empty(lmr_empty)
    );

    stereo_matrix stereo_matrix_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_lpr_dout(lpr_dout),
        .i_lpr_empty(lpr_empty),
        .o_lpr_rd_en(lpr_rd_en),
        .i_lmr_dout(lmr_dout),
        .i_lmr_empty(lmr_empty),
        .o_lmr_rd_en(lmr_rd_en),
        .o_left_wr_en(left_sum_wr_en),
        .o_left_din(left_sum_din),
        .i_left_full(left_sum_full),
        .o_right_wr_en(right_diff_wr_en),
        .o_right_din(right_diff_din),
        .i_right_full(right_diff_full)
    );

    fifo #(.FIFO_DATA_WIDTH(`FM_DATA_SIZE), .FIFO_BUFFER_SIZE(`FM_FIFO_DEPTH)) fifo_sum_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_wr_en(left_sum_wr_en),
        .i_din(left_sum_din),
        .o_full(left_sum_full),
        .i_rd_en(left_sum_rd_en),
        .o_dout(left_sum_dout),
        .o_empty(left_sum_empty)
    );

    fifo #(.FIFO_DATA_WIDTH(`FM_DATA_SIZE), .FIFO_BUFFER_SIZE(`FM_FIFO_DEPTH)) fifo_diff_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_wr_en(right_diff_wr_en),
        .i_din(right_diff_din),
        .o_full(right_diff_full),
        .i_rd_en(right_diff_rd_en),
        .o_dout(right_diff_dout),
        .o_empty(right_diff_empty)
    );

    // volume per channel
    gain gain_left_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_volume(i_volume),
        .i_in_dout(left_sum_dout),
        .i_in_empty(left_sum_empty),
        .o_in_rd_en(left_sum_rd_en),
        .o_out_din(left_gain_din),
        .o_out_wr_en(left_gain_wr_en),
        .i_out_full(left_gain_full)
    );

    gain gain_right_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_volume(i_volume),
        .i_in_dout(right_diff_dout),
        .i_in_empty(right_diff_empty),
        .o_in_rd_en(right_diff_rd_en),
        .o_out_din(right_gain_din),
        .o_out_wr_en(right_gain_wr_en),
        .i_out_full(right_gain_full)
    );

    fifo #(.FIFO_DATA_WIDTH(`FM_DATA_SIZE), .FIFO_BUFFER_SIZE(`FM_FIFO_DEPTH)) fifo_left_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_wr_en(left_gain_wr_en),
        .i_din(left_gain_din),
        .o_full(left_gain_full),
        .i_rd_en(i_left_rd_en),
        .o_dout(o_left_data),
        .o_empty(o_left_empty)
    );

    fifo #(.FIFO_DATA_WIDTH(`FM_DATA_SIZE), .FIFO_BUFFER_SIZE(`FM_FIFO_DEPTH)) fifo_right_inst (
        .clock(clock),
        .i_rst(i_rst),
        .i_wr_en(right_gain_wr_en),
        .i_din(right_gain_din),
        .o_full(right_gain_full),
        .i_rd_en(i_right_rd_en),
        .o_dout(o_right_data),
        .o_empty(o_right_empty)
    );

endmodule

// File: testbench/fm_radio_properties.sv
`timescale 1ns/100ps

module fm_radio_properties (
    input logic clock,
    input logic i_rst,
    input logic i_wr_en,
    input logic i_rd_en,
    input logic o_full,
    input logic o_empty
);

    property no_write_when_full;
        @(posedge clock) disable iff (i_rst) !(i_wr_en && o_full);
    endproperty

    property no_read_when_empty;
        @(posedge clock) disable iff (i_rst) !(i_rd_en && o_empty);
    endproperty

    // an accepted write leaves at least one word for the next cycle
    property write_clears_empty;
        @(posedge clock) disable iff (i_rst) (i_wr_en && !o_full) |=> !o_empty;
    endproperty

    assert property (no_write_when_full)
        else $error("fifo written while full");

    assert property (no_read_when_empty)
        else $error("fifo read while empty");

    assert property (write_clears_empty)
        else $error("fifo still empty the cycle after a write");

endmodule

bind fifo fm_radio_properties fifo_props_i (
    .clock(clock),
    .i_rst(i_rst),
    .i_wr_en(i_wr_en),
    .i_rd_en(i_rd_en),
    .o_full(o_full),
    .o_empty(o_empty)
);

// File: testbench/fm_radio_tb.sv
`timescale 1ns/100ps

module fm_radio_tb;

    logic               clock;
    logic               i_rst;
    logic               i_in_wr_en;
    logic [7:0]         i_in_din;
    logic               o_in_full;
    logic signed [31:0] i_volume;
    logic               i_left_rd_en;
    logic               o_left_empty;
    logic signed [31:0] o_left_data;
    logic               i_right_rd_en;
    logic               o_right_empty;
    logic signed [31:0] o_right_data;

    integer seed;
    integer errors;
    integer checks;
    integer tests;
    integer test_errors;
    integer test_checks;
    integer cycles;
    integer limit;
    integer stall_cycles;
    string  test_name;

    logic [7:0]  byte_q[$];
    logic [31:0] left_q[$];
    logic [31:0] right_q[$];

    fm_radio_top fm_radio_top_i (
        .clock(clock),
        .i_rst(i_rst),
        .i_in_wr_en(i_in_wr_en),
        .i_in_din(i_in_din),
        .o_in_full(o_in_full),
        .i_volume(i_volume),
        .i_left_rd_en(i_left_rd_en),
        .o_left_empty(o_left_empty),
        .o_left_data(o_left_data),
        .i_right_rd_en(i_right_rd_en),
        .o_right_empty(o_right_empty),
        .o_right_data(o_right_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    // watchdog
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors = errors + 1;
        test_errors = test_errors + 1;
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic report_problem(input string what);
        errors = errors + 1;
        test_errors = test_errors + 1;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // I is b1:b0 and Q is b3:b2, each a signed 16-bit field scaled by 1024
    function automatic logic [31:0] rule_output(input logic [7:0] b0, input logic [7:0] b1,
                                                input logic [7:0] b2, input logic [7:0] b3,
                                                input integer vol, input bit want_left);
        integer i_val;
        integer q_val;
        integer mixed;
        integer prod;
        i_val = 32'($signed({b1, b0})) * 1024;
        q_val = 32'($signed({b3, b2})) * 1024;
        mixed = want_left ? i_val + q_val : i_val - q_val;
        prod = mixed * vol;
        return prod >>> 10;
    endfunction

    task automatic queue_frame(input logic [7:0] b0, input logic [7:0] b1,
                               input logic [7:0] b2, input logic [7:0] b3);
        byte_q.push_back(b0);
        byte_q.push_back(b1);
        byte_q.push_back(b2);
        byte_q.push_back(b3);
        left_q.push_back(rule_output(b0, b1, b2, b3, i_volume, 1'b1));
        right_q.push_back(rule_output(b0, b1, b2, b3, i_volume, 1'b0));
    endtask

    // writes every queued byte and drains both outputs
    task automatic run_queued(input integer stall);
        integer n;
        logic   full_s;
        logic   left_empty_s;
        logic   right_empty_s;
        logic   draining;
        logic [31:0] exp;
        n = 0;
        draining = 1'b0;
        while (byte_q.size() > 0 || left_q.size() > 0 || right_q.size() > 0) begin
            @(negedge clock);
            full_s = o_in_full;
            left_empty_s = o_left_empty;
            right_empty_s = o_right_empty;
            if (i_left_rd_en) begin
                exp = left_q.pop_front();
                test_checks = test_checks + 1;
                if (o_left_data !== exp) begin
                    report_mismatch("o_left_data", exp, o_left_data);
                end
            end
            if (i_right_rd_en) begin
                exp = right_q.pop_front();
                test_checks = test_checks + 1;
                if (o_right_data !== exp) begin
                    report_mismatch("o_right_data", exp, o_right_data);
                end
            end
            @(posedge clock);
            n = n + 1;
            // every other cycle at most, so a flag seen at the negedge is never stale
            if (byte_q.size() > 0 && !i_in_wr_en && !full_s) begin
                i_in_wr_en <= 1'b1;
                i_in_din <= byte_q.pop_front();
            end else begin
                i_in_wr_en <= 1'b0;
            end
            // outputs stay unread until the input side is done or backed up
            if (n >= stall && (byte_q.size() == 0 || full_s)) begin
                draining = 1'b1;
            end
            i_left_rd_en <= draining && !i_left_rd_en && !left_empty_s
                            && left_q.size() > 0 && ($random(seed) & 1) != 0;
            i_right_rd_en <= draining && !i_right_rd_en && !right_empty_s
                             && right_q.size() > 0 && ($random(seed) & 1) != 0;
        end
        @(posedge clock);
        i_in_wr_en <= 1'b0;
        i_left_rd_en <= 1'b0;
        i_right_rd_en <= 1'b0;
        repeat (40) @(posedge clock);
        @(negedge clock);
        if (!o_left_empty) begin
            report_problem("left output holds a word that no frame accounts for");
        end
        if (!o_right_empty) begin
            report_problem("right output holds a word that no frame accounts for");
        end
    endtask

    task automatic count_trace_bytes(output integer total);
        integer fd;
        integer code;
        integer a;
        integer frames;
        string  line;
        string  tag;
        total = 0;
        fd = $fopen("testbench/fm_radio_trace.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            code = $sscanf(line, "%s", tag);
            if (code == 1 && tag == "F") begin
                total = total + 4;
            end else if (code == 1 && tag == "R") begin
                code = $sscanf(line, "%s %d %d", tag, a, frames);
                total = total + 4 * frames;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        integer fd;
        integer code;
        integer total;
        integer frames;
        integer vol;
        string  line;
        string  tag;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [7:0]  b3;
        logic [31:0] tl;
        logic [31:0] tr;
        i_rst = 1'b1;
        i_in_wr_en = 1'b0;
        i_in_din = 8'h00;
        i_volume = 32'sd1024;
        i_left_rd_en = 1'b0;
        i_right_rd_en = 1'b0;
        seed = 32'h8bbe_d237;
        errors = 0;
        checks = 0;
        tests = 0;
        cycles = 0;
        limit = 2000;
        stall_cycles = 0;
        count_trace_bytes(total);
        limit = 64 * total + 2000;
        repeat (3) @(posedge clock);
        i_rst <= 1'b0;
        @(negedge clock);
        test_errors = 0;
        test_checks = 3;
        if (o_left_empty !== 1'b1) begin
            report_mismatch("o_left_empty", 32'd1, 32'(o_left_empty));
        end
        if (o_right_empty !== 1'b1) begin
            report_mismatch("o_right_empty", 32'd1, 32'(o_right_empty));
        end
        if (o_in_full !== 1'b0) begin
            report_mismatch("o_in_full", 32'd0, 32'(o_in_full));
        end
        $display("test reset: %0d checks, %0d errors", test_checks, test_errors);
        tests = tests + 1;
        checks = checks + test_checks;
        fd = $fopen("testbench/fm_radio_trace.txt", "r");
        if (fd == 0) begin
            report_problem("could not open the trace file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                code = $sscanf(line, "%s", tag);
                if (code != 1 || tag[0] == 8'h23) begin
                    code = 0;
                end else if (tag == "T") begin
                    code = $sscanf(line, "%s %s", tag, test_name);
                    test_errors = 0;
                    test_checks = 0;
                    stall_cycles = 0;
                end else if (tag == "V") begin
                    code = $sscanf(line, "%s %d", tag, vol);
                    @(posedge clock);
                    i_volume <= vol;
                    @(posedge clock);
                end else if (tag == "F") begin
                    code = $sscanf(line, "%s %h %h %h %h %h %h", tag, b0, b1, b2, b3, tl, tr);
                    test_checks = test_checks + 2;
                    if (tl !== rule_output(b0, b1, b2, b3, i_volume, 1'b1)) begin
                        report_mismatch("trace left value",
                                        rule_output(b0, b1, b2, b3, i_volume, 1'b1), tl);
                    end
                    if (tr !== rule_output(b0, b1, b2, b3, i_volume, 1'b0)) begin
                        report_mismatch("trace right value",
                                        rule_output(b0, b1, b2, b3, i_volume, 1'b0), tr);
                    end
                    queue_frame(b0, b1, b2, b3);
                end else if (tag == "R") begin
                    code = $sscanf(line, "%s %d %d", tag, stall_cycles, frames);
                    repeat (frames) begin
                        queue_frame(8'($random(seed)), 8'($random(seed)),
                                    8'($random(seed)), 8'($random(seed)));
                    end
                end else if (tag == "E") begin
                    run_queued(stall_cycles);
                    $display("test %s: %0d checks, %0d errors", test_name, test_checks,
                             test_errors);
                    tests = tests + 1;
                    checks = checks + test_checks;
                end
            end
            $fclose(fd);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: testbench/fm_radio_trace.txt
# T name | V volume | F b0 b1 b2 b3 left right (hex) | R stall_cycles frames | E
# bytes in arrival order, I is b1:b0 and Q is b3:b2
T unity
V 1024
F 64 00 32 00 00025800 0000c800
F 38 ff 4b 00 fffe0c00 fffbb400
F ff ff ff ff fffff800 00000000
E
T volume_half
V 512
F 64 00 32 00 00012c00 00006400
E
T volume_negative
V -2048
F 0a 00 03 00 ffff9800 ffffc800
E
T volume_zero
V 0
F 64 00 32 00 00000000 00000000
E
T extreme
V 1024
F 00 80 ff 7f fffffc00 00000400
F ff 7f 00 80 fffffc00 fffffc00
E
T backpressure
V 300
R 600 200
E

// File: compile.f
+incdir+rtl
rtl/fm_radio_pkg.sv
rtl/fifo.sv
rtl/read_iq.sv
rtl/stereo_matrix.sv
rtl/gain.sv
rtl/fm_radio_top.sv
testbench/fm_radio_properties.sv
testbench/fm_radio_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the FM radio testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fm_radio_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vfm_radio_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
